/* build.f */
+incdir+include
rtl/core_pkg.sv
rtl/stage_if.sv
rtl/fetch_stage.sv
rtl/reg_file.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/mem_wb_stage.sv
rtl/rv_core.sv
bench/rv_core_tb.sv

/* Bender.yml */
package:
  name: rv_core

export_include_dirs:
  - include

sources:
  - rtl/core_pkg.sv
  - rtl/stage_if.sv
  - rtl/fetch_stage.sv
  - rtl/reg_file.sv
  - rtl/decode_stage.sv
  - rtl/execute_stage.sv
  - rtl/mem_wb_stage.sv
  - rtl/rv_core.sv
  - target: test
    files:
      - bench/rv_core_tb.sv

/* bench/rv_core_tb.sv */
// ##############################
// Random program, memory models
// and reference checks for the core
// ##############################
`timescale 1ns/100ps
`default_nettype none

`include "core_settings.svh"

module rv_core_tb;

  localparam int          N_INSN     = 120;
  localparam int          PROG_WORDS = N_INSN * 4;   // Each instruction plus three NOPs
  localparam logic [31:0] NOP        = 32'h0000_0013; // ADDI x0, x0, 0
  localparam int          K_ALU      = 0;
  localparam int          K_LOAD     = 1;
  localparam int          K_STORE    = 2;
  localparam int          K_NOP      = 3;

  logic             clk;
  logic             arst_n;
  logic [`XLEN-1:0] imem_addr;
  logic [`XLEN-1:0] imem_data;
  logic             imem_ready;
  logic [`XLEN-1:0] dmem_addr;
  logic [`XLEN-1:0] dmem_wdata;
  logic             dmem_we;
  logic             dmem_re;
  logic [`XLEN-1:0] dmem_rdata;
  logic             wb_valid;
  logic [4:0]       wb_rd;
  logic [`XLEN-1:0] wb_data;
  logic [`XLEN-1:0] exp_pc;

  logic [31:0] prog  [0:PROG_WORDS-1];
  logic [31:0] dmem  [0:255];
  logic [31:0] mregs [0:31];  // Reference register file
  logic [31:0] mmem  [0:255]; // Reference data memory

  // Expected retire records, in program order
  int          exp_kind [$];
  int          exp_idx  [$];
  logic [4:0]  exp_rd   [$];
  logic [31:0] exp_data [$];
  logic [31:0] exp_addr [$];

  integer seed;
  int     errors       = 0;
  int     retired      = 0;
  int     total        = 0;
  int     cycles       = 0;
  int     stall_cycles = 0;
  int     stall_left   = 0;
  int     limit        = 0;

  rv_core rv_core_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .imem_addr (imem_addr),
    .imem_data (imem_data),
    .imem_ready(imem_ready),
    .dmem_addr (dmem_addr),
    .dmem_wdata(dmem_wdata),
    .dmem_we   (dmem_we),
    .dmem_re   (dmem_re),
    .dmem_rdata(dmem_rdata),
    .wb_valid  (wb_valid),
    .wb_rd     (wb_rd),
    .wb_data   (wb_data)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Past the program the opcode 7'h7f decodes as a bubble
  assign imem_data = (imem_addr < PROG_WORDS * 4) ? prog[imem_addr[31:2]] :
                     {imem_addr[31:7] ^ imem_addr[24:0], 7'h7f};
  assign dmem_rdata = dmem[dmem_addr[9:2]]; // 256 words that wrap

  always @(posedge clk) begin
    if (dmem_we) dmem[dmem_addr[9:2]] <= dmem_wdata;
  end

  function automatic logic [31:0] sext12(input logic [11:0] imm);
    sext12 = {{20{imm[11]}}, imm};
  endfunction

  // RV32I arithmetic by funct3 with alt as instruction bit 30
  function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                           input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'd0:    alu_ref = alt ? a - b : a + b;
      3'd1:    alu_ref = a << b[4:0];
      3'd2:    alu_ref = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3:    alu_ref = (a < b) ? 32'd1 : 32'd0;
      3'd4:    alu_ref = a ^ b;
      3'd5:    alu_ref = alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6:    alu_ref = a | b;
      default: alu_ref = a & b;
    endcase
  endfunction

  function automatic string kind_name(input int kind);
    case (kind)
      K_ALU:   kind_name = "alu";
      K_LOAD:  kind_name = "lw";
      K_STORE: kind_name = "sw";
      default: kind_name = "nop";
    endcase
  endfunction

  task automatic expect_retire(input int kind, input int idx, input logic [4:0] rd,
                               input logic [31:0] data, input logic [31:0] addr);
    exp_kind.push_back(kind);
    exp_idx.push_back(idx);
    exp_rd.push_back(rd);
    exp_data.push_back(data);
    exp_addr.push_back(addr);
  endtask

  // Generates the program and runs the reference model alongside
  task automatic build_program();
    int          sel;
    int          w;
    logic        alt;
    logic        wr;
    logic [2:0]  f3;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [11:0] imm;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] val;
    logic [31:0] addr;
    logic [31:0] insn;
    for (int i = 0; i < 32; i++) mregs[i] = '0;
    for (int i = 0; i < 256; i++) begin
      val     = $random(seed);
      dmem[i] <= val;
      mmem[i] = val;
    end
    w = 0;
    for (int n = 0; n < N_INSN; n++) begin
      sel  = $unsigned($random(seed)) % 8;
      rd   = $random(seed);
      rs1  = $random(seed);
      rs2  = $random(seed);
      imm  = $random(seed);
      f3   = $random(seed);
      alt  = $random(seed);
      a    = mregs[rs1];
      b    = mregs[rs2];
      wr   = 1'b1;
      case (sel)
        0, 1: begin
          alt  = alt & (f3 == 3'd0 || f3 == 3'd5); // SUB and SRA only
          insn = {1'b0, alt, 5'b0, rs2, rs1, f3, rd, 7'b0110011};
          val  = alu_ref(f3, alt, a, b);
          expect_retire(K_ALU, n, rd, val, '0);
        end
        2, 3: begin
          if (f3 == 3'd1 || f3 == 3'd5) imm[11:5] = {1'b0, alt & (f3 == 3'd5), 5'b0};
          insn = {imm, rs1, f3, rd, 7'b0010011};
          val  = alu_ref(f3, f3 == 3'd5 && imm[10], a, sext12(imm));
          expect_retire(K_ALU, n, rd, val, '0);
        end
        4: begin
          val  = $random(seed);
          insn = {val[31:12], rd, 7'b0110111};
          val  = {val[31:12], 12'b0};
          expect_retire(K_ALU, n, rd, val, '0);
        end
        5: begin
          imm[1:0] = 2'b00 - a[1:0]; // Word aligned address
          addr     = a + sext12(imm);
          val      = mmem[addr[9:2]];
          insn     = {imm, rs1, 3'b010, rd, 7'b0000011};
          expect_retire(K_LOAD, n, rd, val, addr);
        end
        6: begin
          imm[1:0] = 2'b00 - a[1:0];
          addr     = a + sext12(imm);
          insn     = {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
          mmem[addr[9:2]] = b;
          wr       = 1'b0;
          expect_retire(K_STORE, n, 5'd0, b, addr);
        end
        default: begin
          insn      = $random(seed);
          insn[6:0] = f3[0] ? 7'b1100011 : 7'b0010111; // Branch or AUIPC that never retires
          wr        = 1'b0;
        end
      endcase
      if (wr && rd != 5'd0) mregs[rd] = val;
      prog[w] = insn;
      for (int k = 1; k < 4; k++) begin
        prog[w+k] = NOP;
        expect_retire(K_NOP, n, 5'd0, 32'd0, 32'd0);
      end
      w = w + 4;
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
      errors++;
    end
  endtask

  task automatic check_retire();
    int          kind;
    int          idx;
    logic [4:0]  rd;
    logic [31:0] data;
    logic [31:0] addr;
    string       name;
    if (exp_kind.size() == 0) begin
      $display("Unexpected retire of rd %0d with data %h after the program", wb_rd, wb_data);
      errors++;
    end else begin
      kind = exp_kind.pop_front();
      idx  = exp_idx.pop_front();
      rd   = exp_rd.pop_front();
      data = exp_data.pop_front();
      addr = exp_addr.pop_front();
      name = $sformatf("%s #%0d", kind_name(kind), idx);
      if (kind == K_STORE) begin
        check_value({name, " we"}, 32'd1, {31'd0, dmem_we});
        check_value({name, " addr"}, addr, dmem_addr);
        check_value({name, " wdata"}, data, dmem_wdata);
        check_value({name, " rd"}, 32'd0, {27'd0, wb_rd});
        check_value({name, " data"}, 32'd0, wb_data);
      end else begin
        check_value({name, " rd"}, {27'd0, rd}, {27'd0, wb_rd});
        check_value({name, " data"}, data, wb_data);
        check_value({name, " re"}, {31'd0, kind == K_LOAD}, {31'd0, dmem_re});
        check_value({name, " we"}, 32'd0, {31'd0, dmem_we});
        if (kind == K_LOAD) check_value({name, " addr"}, addr, dmem_addr);
      end
      retired++;
    end
  endtask

  // Outputs sampled at the rising edge before the registers update
  always @(posedge clk) begin
    if (!arst_n) begin
      exp_pc <= `RESET_PC;
    end else begin
      check_value("fetch addr", exp_pc, imem_addr);
      if (imem_ready) exp_pc <= exp_pc + 32'd4; // One word per unstalled edge
      if (!imem_ready) begin
        assert (!wb_valid && !dmem_we && !dmem_re) else begin
          $display("Retire or memory strobe active while imem_ready is low");
          errors++;
        end
      end
      if (wb_valid) begin
        check_retire();
      end else begin
        assert (!dmem_we && !dmem_re) else begin
          $display("Memory strobe without a retiring instruction");
          errors++;
        end
      end
    end
  end

  initial begin
    seed       = 32'h45db6962;
    arst_n     = 1'b0;
    imem_ready = 1'b1;
    build_program();
    total = exp_kind.size();
    limit = PROG_WORDS * 4 + 20;
    repeat (2) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    while (retired < total && cycles < limit) begin
      @(negedge clk);
      cycles++;
      if (stall_left == 0 && imem_ready && ($unsigned($random(seed)) % 8) == 0)
        stall_left = 1 + $unsigned($random(seed)) % 3;
      if (stall_left > 0) begin
        imem_ready = 1'b0;
        stall_left--;
        stall_cycles++;
      end else begin
        imem_ready = 1'b1;
      end
      limit = PROG_WORDS * 4 + stall_cycles + 20;
    end
    imem_ready = 1'b1;
    if (retired < total) begin
      $display("Timeout after %0d cycles, %0d of %0d instructions retired",
               cycles, retired, total);
      errors++;
    end else begin
      repeat (5) @(negedge clk); // Nothing may retire past the program
    end
    $display("Retired %0d of %0d, stall cycles %0d, errors %0d",
             retired, total, stall_cycles, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* rtl/rv_core.sv */
// ##############################
// RV32I core top level
// ##############################
`timescale 1ns/100ps
`default_nettype none

`include "core_settings.svh"

module rv_core (
  input  logic                clk,
  input  logic                arst_n,
  output logic [`XLEN-1:0]    imem_addr,
  input  logic [`XLEN-1:0]    imem_data,
  input  logic                imem_ready,  // Low freezes every stage
  output logic [`XLEN-1:0]    dmem_addr,
  output logic [`XLEN-1:0]    dmem_wdata,
  output logic                dmem_we,
  output logic                dmem_re,
  input  logic [`XLEN-1:0]    dmem_rdata,
  output logic                wb_valid,
  output core_pkg::reg_addr_t wb_rd,
  output logic [`XLEN-1:0]    wb_data
);

  logic                stall;
  core_pkg::reg_addr_t rs1;
  core_pkg::reg_addr_t rs2;
  logic [`XLEN-1:0]    rs1_data;
  logic [`XLEN-1:0]    rs2_data;
  logic                wr_en;
  core_pkg::reg_addr_t wr_addr;
  logic [`XLEN-1:0]    wr_data;

  fetch_dec_if fd_if ();
  dec_ex_if    de_if ();
  ex_wb_if     ew_if ();

  assign stall = ~imem_ready;

  fetch_stage fetch_stage_i (
    .clk      (clk),
    .arst_n   (arst_n),
    .stall    (stall),
    .imem_addr(imem_addr),
    .imem_data(imem_data),
    .fd       (fd_if.src)
  );

  reg_file reg_file_i (
    .clk     (clk),
    .arst_n  (arst_n),
    .rs1     (rs1),
    .rs2     (rs2),
    .rs1_data(rs1_data),
    .rs2_data(rs2_data),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data)
  );

  decode_stage decode_stage_i (
    .clk     (clk),
    .arst_n  (arst_n),
    .stall   (stall),
    .fd      (fd_if.dst),
    .rs1     (rs1),
    .rs2     (rs2),
    .rs1_data(rs1_data),
    .rs2_data(rs2_data),
    .de      (de_if.src)
  );

  execute_stage execute_stage_i (
    .clk   (clk),
    .arst_n(arst_n),
    .stall (stall),
    .de    (de_if.dst),
    .ew    (ew_if.src)
  );

  mem_wb_stage mem_wb_stage_i (
    .stall     (stall),
    .ew        (ew_if.dst),
    .dmem_addr (dmem_addr),
    .dmem_wdata(dmem_wdata),
    .dmem_we   (dmem_we),
    .dmem_re   (dmem_re),
    .dmem_rdata(dmem_rdata),
    .wr_en     (wr_en),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data),
    .wb_valid  (wb_valid),
    .wb_rd     (wb_rd),
    .wb_data   (wb_data)
  );

endmodule

`default_nettype wire

/* rtl/mem_wb_stage.sv */
// ##############################
// Data memory access, writeback
// and retire trace
// ##############################
`timescale 1ns/100ps
`default_nettype none

`include "core_settings.svh"

module mem_wb_stage (
  input  logic                stall,
  ex_wb_if.dst                ew,
  output logic [`XLEN-1:0]    dmem_addr,
  output logic [`XLEN-1:0]    dmem_wdata,
  output logic                dmem_we,
  output logic                dmem_re,
  input  logic [`XLEN-1:0]    dmem_rdata,
  output logic                wr_en,
  output core_pkg::reg_addr_t wr_addr,
  output logic [`XLEN-1:0]    wr_data,
  output logic                wb_valid,
  output core_pkg::reg_addr_t wb_rd,
  output logic [`XLEN-1:0]    wb_data
);

  logic fire; // Instruction completes this cycle

  assign fire = ew.valid & ~stall;

  assign dmem_addr  = ew.result;
  assign dmem_wdata = ew.store_data;
  assign dmem_we    = fire && (ew.mem_op == core_pkg::MEM_STORE);
  assign dmem_re    = fire && (ew.mem_op == core_pkg::MEM_LOAD);

  assign wr_en   = fire & ew.rd_en;
  assign wr_addr = ew.rd;
  assign wr_data = (ew.mem_op == core_pkg::MEM_LOAD) ? dmem_rdata : ew.result;

  // Stores show up with rd and data zero
  assign wb_valid = fire;
  assign wb_rd    = ew.rd_en ? ew.rd : '0;
  assign wb_data  = ew.rd_en ? wr_data : '0;

endmodule

`default_nettype wire

/* rtl/execute_stage.sv */
// ##############################
// ALU and execute register
// ##############################
`timescale 1ns/100ps
`default_nettype none

`include "core_settings.svh"

module execute_stage (
  input  logic  clk,
  input  logic  arst_n,
  input  logic  stall,
  dec_ex_if.dst de,
  ex_wb_if.src  ew
);

  logic [`XLEN-1:0] alu_res;
  logic [4:0]       shamt;

  assign shamt = de.op_b[4:0];

  always_comb begin
    case (de.alu_op)
      core_pkg::ALU_ADD:  alu_res = de.op_a + de.op_b; // Also load/store address
      core_pkg::ALU_SUB:  alu_res = de.op_a - de.op_b;
      core_pkg::ALU_SLL:  alu_res = de.op_a << shamt;
      core_pkg::ALU_SLT:  alu_res = {{(`XLEN-1){1'b0}}, $signed(de.op_a) < $signed(de.op_b)};
      core_pkg::ALU_SLTU: alu_res = {{(`XLEN-1){1'b0}}, de.op_a < de.op_b};
      core_pkg::ALU_XOR:  alu_res = de.op_a ^ de.op_b;
      core_pkg::ALU_SRL:  alu_res = de.op_a >> shamt;
      core_pkg::ALU_SRA:  alu_res = $unsigned($signed(de.op_a) >>> shamt);
      core_pkg::ALU_OR:   alu_res = de.op_a | de.op_b;
      core_pkg::ALU_AND:  alu_res = de.op_a & de.op_b;
      default:            alu_res = de.op_b; // LUI
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) ew.valid <= 1'b0;
    else if (!stall) ew.valid <= de.valid;
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      ew.mem_op     <= de.mem_op;
      ew.rd         <= de.rd;
      ew.rd_en      <= de.rd_en;
      ew.result     <= alu_res;
      ew.store_data <= de.store_data;
    end
  end

endmodule

`default_nettype wire

/* rtl/decode_stage.sv */
// ##############################
// Instruction decode, immediates
// and the decode register
// ##############################
`timescale 1ns/100ps
`default_nettype none

`include "core_settings.svh"

module decode_stage (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                stall,
  fetch_dec_if.dst            fd,
  output core_pkg::reg_addr_t rs1,
  output core_pkg::reg_addr_t rs2,
  input  logic [`XLEN-1:0]    rs1_data,
  input  logic [`XLEN-1:0]    rs2_data,
  dec_ex_if.src               de
);

  logic [`XLEN-1:0]  imm_i;
  logic [`XLEN-1:0]  imm_s;
  logic [`XLEN-1:0]  imm_u;
  logic [`XLEN-1:0]  op_b;
  logic              alt;      // Bit 30 selects SUB or SRA
  logic              dec_ok;
  logic              rd_en;
  core_pkg::alu_op_t arith_op;
  core_pkg::alu_op_t alu_op;
  core_pkg::mem_op_t mem_op;

  assign rs1 = fd.insn.r.rs1;
  assign rs2 = fd.insn.r.rs2;

  assign imm_i = {{(`XLEN-12){fd.insn.i.imm[11]}}, fd.insn.i.imm};
  assign imm_s = {{(`XLEN-12){fd.insn.s.imm_hi[6]}}, fd.insn.s.imm_hi, fd.insn.s.imm_lo};
  assign imm_u = {fd.insn.u.imm, 12'b0};

  // For OP-IMM only the shifts look at bit 30
  assign alt = fd.insn.r.funct7[5] &
               ((fd.insn.r.opcode == core_pkg::OPC_OP) || (fd.insn.r.funct3 == 3'b101));

  always_comb begin
    case (fd.insn.r.funct3)
      3'b000:  arith_op = alt ? core_pkg::ALU_SUB : core_pkg::ALU_ADD;
      3'b001:  arith_op = core_pkg::ALU_SLL;
      3'b010:  arith_op = core_pkg::ALU_SLT;
      3'b011:  arith_op = core_pkg::ALU_SLTU;
      3'b100:  arith_op = core_pkg::ALU_XOR;
      3'b101:  arith_op = alt ? core_pkg::ALU_SRA : core_pkg::ALU_SRL;
      3'b110:  arith_op = core_pkg::ALU_OR;
      default: arith_op = core_pkg::ALU_AND;
    endcase
  end

  always_comb begin
    dec_ok = 1'b1;
    rd_en  = 1'b1;
    alu_op = arith_op;
    mem_op = core_pkg::MEM_NONE;
    op_b   = rs2_data;
    case (fd.insn.r.opcode)
      core_pkg::OPC_OP:     op_b = rs2_data;
      core_pkg::OPC_OP_IMM: op_b = imm_i;
      core_pkg::OPC_LUI: begin
        alu_op = core_pkg::ALU_PASS_B;
        op_b   = imm_u;
      end
      core_pkg::OPC_LOAD: begin
        alu_op = core_pkg::ALU_ADD;
        mem_op = core_pkg::MEM_LOAD;
        op_b   = imm_i;
        dec_ok = (fd.insn.i.funct3 == 3'b010); // LW only
      end
      core_pkg::OPC_STORE: begin
        alu_op = core_pkg::ALU_ADD;
        mem_op = core_pkg::MEM_STORE;
        op_b   = imm_s;
        rd_en  = 1'b0;
        dec_ok = (fd.insn.s.funct3 == 3'b010); // SW only
      end
      default: begin
        dec_ok = 1'b0; // Retires as a bubble
        rd_en  = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) de.valid <= 1'b0;
    else if (!stall) de.valid <= fd.valid & dec_ok;
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      de.alu_op     <= alu_op;
      de.mem_op     <= mem_op;
      de.rd         <= fd.insn.r.rd;
      de.rd_en      <= rd_en;
      de.op_a       <= rs1_data;
      de.op_b       <= op_b;
      de.store_data <= rs2_data;
    end
  end

endmodule

`default_nettype wire

/* rtl/reg_file.sv */
// ##############################
// Integer register file
// ##############################
`timescale 1ns/100ps
`default_nettype none

`include "core_settings.svh"

module reg_file (
  input  logic                clk,
  input  logic                arst_n,
  input  core_pkg::reg_addr_t rs1,
  input  core_pkg::reg_addr_t rs2,
  output logic [`XLEN-1:0]    rs1_data,
  output logic [`XLEN-1:0]    rs2_data,
  input  logic                wr_en,
  input  core_pkg::reg_addr_t wr_addr,
  input  logic [`XLEN-1:0]    wr_data
);

  logic [`XLEN-1:0] regs [1:`REG_COUNT-1]; // x0 has no storage

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 1; i < `REG_COUNT; i++) regs[i] <= '0;
    end else if (wr_en && wr_addr != '0) begin
      regs[wr_addr] <= wr_data;
    end
  end

  // Write-through keeps a same-cycle writeback visible to decode
  assign rs1_data = (rs1 == '0)                 ? '0      :
                    (wr_en && wr_addr == rs1)   ? wr_data : regs[rs1];
  assign rs2_data = (rs2 == '0)                 ? '0      :
                    (wr_en && wr_addr == rs2)   ? wr_data : regs[rs2];

endmodule

`default_nettype wire

/* rtl/fetch_stage.sv */
// ##############################
// Program counter and fetch reg
// ##############################
`timescale 1ns/100ps
`default_nettype none

`include "core_settings.svh"

module fetch_stage (
  input  logic             clk,
  input  logic             arst_n,
  input  logic             stall,
  output logic [`XLEN-1:0] imem_addr,
  input  logic [`XLEN-1:0] imem_data,
  fetch_dec_if.src         fd
);

  logic [`XLEN-1:0] pc;

  assign imem_addr = pc; // Memory answers in the same cycle

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc       <= `RESET_PC;
      fd.valid <= 1'b0;
    end else if (!stall) begin
      pc       <= pc + `XLEN'd4;
      fd.valid <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      fd.pc   <= pc;
      fd.insn <= imem_data;
    end
  end

endmodule

`default_nettype wire

/* rtl/stage_if.sv */
// ##############################
// Pipeline stage interfaces
// ##############################
`timescale 1ns/100ps
`default_nettype none

`include "core_settings.svh"

// Fetch register contents
interface fetch_dec_if;
  logic                valid;
  logic [`XLEN-1:0]    pc;
  core_pkg::insn_t     insn;

  modport src (output valid, pc, insn);
  modport dst (input valid, pc, insn);
endinterface

interface dec_ex_if;
  logic                valid;
  core_pkg::alu_op_t   alu_op;
  core_pkg::mem_op_t   mem_op;
  core_pkg::reg_addr_t rd;
  logic                rd_en;
  logic [`XLEN-1:0]    op_a;
  logic [`XLEN-1:0]    op_b;
  logic [`XLEN-1:0]    store_data;

  modport src (output valid, alu_op, mem_op, rd, rd_en, op_a, op_b, store_data);
  modport dst (input valid, alu_op, mem_op, rd, rd_en, op_a, op_b, store_data);
endinterface

// Result doubles as data address for loads and stores
interface ex_wb_if;
  logic                valid;
  core_pkg::mem_op_t   mem_op;
  core_pkg::reg_addr_t rd;
  logic                rd_en;
  logic [`XLEN-1:0]    result;
  logic [`XLEN-1:0]    store_data;

  modport src (output valid, mem_op, rd, rd_en, result, store_data);
  modport dst (input valid, mem_op, rd, rd_en, result, store_data);
endinterface

`default_nettype wire

/* rtl/core_pkg.sv */
// ##############################
// Opcodes, instruction views and
// ALU and memory operation types
// ##############################
`default_nettype none

package core_pkg;

  typedef logic [4:0] reg_addr_t;

  // Major opcodes handled by the core
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011
  } opcode_t;

  typedef struct packed {
    logic [6:0] funct7;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    reg_addr_t  rd;
    opcode_t    opcode;
  } r_type_t;

  typedef struct packed {
    logic [11:0] imm;
    reg_addr_t   rs1;
    logic [2:0]  funct3;
    reg_addr_t   rd;
    opcode_t     opcode;
  } i_type_t;

  typedef struct packed {
    logic [6:0] imm_hi; // imm[11:5]
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo; // imm[4:0]
    opcode_t    opcode;
  } s_type_t;

  typedef struct packed {
    logic [19:0] imm;   // imm[31:12]
    reg_addr_t   rd;
    opcode_t     opcode;
  } u_type_t;

  // Same word, decoded per format
  typedef union packed {
    r_type_t r;
    i_type_t i;
    s_type_t s;
    u_type_t u;
  } insn_t;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
    ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
  } alu_op_t;

  typedef enum logic [1:0] {
    MEM_NONE,
    MEM_LOAD,
    MEM_STORE
  } mem_op_t;

endpackage

`default_nettype wire

/* include/core_settings.svh */
// ##############################
// Core width, register count
// and reset address macros
// ##############################
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

`define XLEN      32            // Data and address width
`define REG_COUNT 32
`define RESET_PC  32'h0000_0000 // First fetch address

`endif
